/* exec_stimulus.txt */
// columns: op csr rs1 rs2 imm pc result taken target, all hex, one operation per line
// op and csr use the package encodings, columns an operation does not use are zero
0 000 ffffffffffffffff 0000000000000001 0 0 0000000000000000 0 0
1 000 0000000000000000 0000000000000001 0 0 ffffffffffffffff 0 0
0 000 00000000ffffffff 0000000000000001 0 0 0000000100000000 0 0
0 000 7fffffffffffffff 0000000000000001 0 0 8000000000000000 0 0
1 000 8000000000000000 0000000000000001 0 0 7fffffffffffffff 0 0
1 000 0000000100000000 00000000000000ff 0 0 00000000ffffff01 0 0
0 000 123456789abcdef0 0fedcba987654321 0 0 2222222222222211 0 0
1 000 1000000000000000 0000000000000001 0 0 0fffffffffffffff 0 0
2 000 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 0 0 f000f000f000f000 0 0
3 000 f0f0f0f0f0f0f0f0 0f0f0f0f00000000 0 0 fffffffff0f0f0f0 0 0
4 000 0123456789abcdef ffffffffffffffff 0 0 fedcba9876543210 0 0
4 000 aaaaaaaaaaaaaaaa 5555555555555555 0 0 ffffffffffffffff 0 0
7 000 80000000000000ff 00000000000000ff 0000000000000010 0000000000001000 0 1 0000000000001010
8 000 80000000000000ff 00000000000000ff fffffffffffffff0 0000000000001000 0 0 0000000000000ff0
9 000 80000000000000ff 00000000000000ff 0000000000000004 00000000000010fc 0 0 0000000000001100
a 000 80000000000000ff 00000000000000ff 0000000000000001 00000000000000ff 0 1 0000000000000100
7 000 00000000000000ff 80000000000000ff 0000000080000000 0000000080000000 0 0 0000000100000000
8 000 00000000000000ff 80000000000000ff 0000000000000001 00000000ffffffff 0 1 0000000100000000
9 000 00000000000000ff 80000000000000ff 0000000000000001 ffffffffffffffff 0 1 0000000000000000
a 000 00000000000000ff 80000000000000ff 0000000000000800 0000000000002000 0 0 0000000000002800
8 000 80000000000000ff 80000000000000ff 0000000000000004 0000000000004000 0 1 0000000000004004
5 000 1122334455667788 1122334455667789 00000000000000f8 0000000000003000 0 0 00000000000030f8
6 000 1122334455667788 1122334455667789 ffffffffffffff00 0000000000003000 0 1 0000000000002f00
5 000 1122334455667788 1122334455667788 0000000000000001 12345678000000ff 0 1 1234567800000100
7 000 fffffffffffffffe ffffffffffffffff 0000000000000100 0000000000000100 0 1 0000000000000200
b 000 0000000000000000 0000000000000000 0000000000000100 00000000000fff00 0 1 0000000000100000
b 000 0000000000000000 0000000000000000 0000000000000008 7ffffffffffffffc 0 1 8000000000000004
d 305 0000000000000000 0 0 0 0000000080000100 0 0
c 305 00000000c0000fff 0 0 0 0000000080000100 0 0
d 305 0000000000000000 0 0 0 00000000c0000ffc 0 0
c 340 0123456789abcdef 0 0 0 0000000000000000 0 0
d 340 f000000000000000 0 0 0 0123456789abcdef 0 0
e 340 000000000000000f 0 0 0 f123456789abcdef 0 0
c 340 0000000000000000 0 0 0 f123456789abcde0 0 0
d 340 0000000000000000 0 0 0 0000000000000000 0 0
c 300 ffffffffffffffff 0 0 0 0000000000000000 0 0
d 300 0000000000000000 0 0 0 0000000000000000 0 0
0 000 00000000000000ff 00000000000000ff 0 0 00000000000001fe 0 0

/* sim.f */
exec_pkg.sv
byte_alu.sv
branch_unit.sv
csr_bank.sv
serial_exec.sv
serial_exec_tb.sv

/* Makefile */
# Verilator build and run for the byte-serial execute stage

VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing -Wno-fatal
TOP             ?= serial_exec_tb
OBJ_DIR         ?= obj_dir
FILE_LIST       ?= sim.f
PASS_TEXT       ?= TEST PASS

SOURCES := $(shell cat $(FILE_LIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* serial_exec_tb.sv */
// testbench for the byte-serial execute stage, replays exec_stimulus.txt with random idle gaps
`default_nettype none

module serial_exec_tb;

    // mtvec reset value, low two bits set so the alignment mask shows on the first read
    localparam logic [63:0] trap_vector = 64'h0000_0000_8000_0103;
    localparam int max_ops = 64;
    // op csr rs1 rs2 imm pc result taken target
    localparam int fields = 9;

    logic                  clock;
    logic                  reset;
    logic                  beat_valid;
    exec_pkg::exec_beat_t  beat;
    logic                  result_valid;
    exec_pkg::byte_t       result;
    logic                  branch_valid;
    exec_pkg::branch_out_t branch;

    // flat record memory, nine words per operation
    logic [63:0] stim_mem [0:max_ops*fields-1];
    logic [63:0] exp_result_q[$];
    logic [64:0] exp_branch_q[$];
    logic [63:0] exp_result;
    logic [64:0] exp_branch;
    logic [63:0] result_acc;
    logic [31:0] lfsr_state;
    int          num_ops;
    int          byte_count;
    int          cycle_count;
    int          timeout_limit;
    int          check_count;
    int          value_errors;
    int          other_errors;

    serial_exec #(
        .reset_trap_vector (trap_vector)
    ) dut_i (
        .clock        (clock),
        .reset        (reset),
        .beat_valid   (beat_valid),
        .beat         (beat),
        .result_valid (result_valid),
        .result       (result),
        .branch_valid (branch_valid),
        .branch       (branch)
    );

    always #4 clock = ~clock;

    // fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // one step per bit taken, a set bit asks for an idle cycle
    task automatic take_gap_bit(output logic gap);
        lfsr_state = lfsr_next(lfsr_state);
        gap = lfsr_state[0];
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        check_count++;
        if (got !== expected) begin
            value_errors++;
            $display("Error: %s got 0x%h expected 0x%h at time %0t", name, got, expected, $time);
        end
    endtask

    // queue the expectation, then send eight beats lowest byte first
    task automatic drive_op(input int base);
        exec_pkg::op_t       op;
        exec_pkg::csr_addr_t csr;
        logic                gap;
        op = exec_pkg::op_t'(stim_mem[base][3:0]);
        csr = exec_pkg::csr_addr_t'(stim_mem[base+1][11:0]);
        case (op)
            exec_pkg::ADD, exec_pkg::SUB, exec_pkg::AND, exec_pkg::OR, exec_pkg::XOR,
            exec_pkg::CSRRW, exec_pkg::CSRRS, exec_pkg::CSRRC:
                exp_result_q.push_back(stim_mem[base+6]);
            exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::BLT, exec_pkg::BGE,
            exec_pkg::BLTU, exec_pkg::BGEU, exec_pkg::JAL:
                exp_branch_q.push_back({stim_mem[base+7][0], stim_mem[base+8]});
            default: begin
                other_errors++;
                $display("operation %0d in the stimulus file has an unknown opcode", base / fields);
            end
        endcase
        for (int part = 0; part < exec_pkg::xlen_bytes; part++) begin
            take_gap_bit(gap);
            if (gap) begin
                beat_valid = 1'b0;
                @(negedge clock);
            end
            beat_valid = 1'b1;
            beat.op = op;
            beat.csr = csr;
            beat.rs1 = stim_mem[base+2][part*8 +: 8];
            beat.rs2 = stim_mem[base+3][part*8 +: 8];
            beat.imm = stim_mem[base+4][part*8 +: 8];
            beat.pc = stim_mem[base+5][part*8 +: 8];
            @(negedge clock);
        end
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clock) begin
        if (!reset && result_valid) begin
            result_acc[byte_count*8 +: 8] = result;
            if (byte_count == exec_pkg::xlen_bytes - 1) begin
                byte_count = 0;
                if (exp_result_q.size() == 0) begin
                    other_errors++;
                    $display("a result word arrived with no ALU or CSR operation pending");
                end else begin
                    exp_result = exp_result_q.pop_front();
                    check_value("result", result_acc, exp_result);
                end
            end else begin
                byte_count++;
            end
        end
        if (!reset && branch_valid) begin
            if (exp_branch_q.size() == 0) begin
                other_errors++;
                $display("a branch pulse arrived with no branch operation pending");
            end else begin
                exp_branch = exp_branch_q.pop_front();
                check_value("branch.taken", {63'b0, branch.taken}, {63'b0, exp_branch[64]});
                check_value("branch.target", branch.target, exp_branch[63:0]);
            end
        end
    end

    // each operation needs at most sixteen cycles with every gap taken
    initial begin
        cycle_count = 0;
        @(posedge clock);
        while (cycle_count < timeout_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("run did not finish within %0d cycles, results are missing", timeout_limit);
        $display("checks %0d, value errors %0d, other errors %0d",
                 check_count, value_errors, other_errors + 1);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        beat_valid = 1'b0;
        beat = '0;
        lfsr_state = 32'h1a6dbbbc;
        byte_count = 0;
        result_acc = '0;
        check_count = 0;
        value_errors = 0;
        other_errors = 0;
        // unused words keep a pattern of their own address, which marks the end of the file
        for (int i = 0; i < max_ops * fields; i++) begin
            stim_mem[i] = ~64'(i);
        end
        $readmemh("exec_stimulus.txt", stim_mem);
        num_ops = 0;
        while (num_ops < max_ops && stim_mem[num_ops*fields] != ~64'(num_ops * fields)) begin
            num_ops++;
        end
        if (num_ops == 0) begin
            other_errors++;
            $display("the stimulus file holds no operations");
        end
        timeout_limit = 8 + num_ops * 16 + 64;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int op_index = 0; op_index < num_ops; op_index++) begin
            drive_op(op_index * fields);
        end
        beat_valid = 1'b0;
        while (exp_result_q.size() != 0 || exp_branch_q.size() != 0) begin
            @(negedge clock);
        end
        // a few idle cycles to catch stray pulses
        repeat (4) @(negedge clock);
        if (byte_count != 0) begin
            other_errors++;
            $display("result bytes were left over after the last operation");
        end
        $display("checks %0d, value errors %0d, other errors %0d",
                 check_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* serial_exec.sv */
// top of the byte-serial execute stage, counts beats and registers ALU, CSR and branch results
`default_nettype none

module serial_exec #(
    parameter logic [exec_pkg::xlen_bytes*8-1:0] reset_trap_vector = '0
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  beat_valid,
    input  exec_pkg::exec_beat_t  beat,
    output logic                  result_valid,
    output exec_pkg::byte_t       result,
    output logic                  branch_valid,
    output exec_pkg::branch_out_t branch
);

    localparam exec_pkg::part_t last_part = exec_pkg::part_t'(exec_pkg::xlen_bytes - 1);

    // beat index of the current operation, holds through idle cycles
    exec_pkg::part_t       part;
    exec_pkg::byte_t       alu_byte;
    exec_pkg::byte_t       csr_byte;
    exec_pkg::branch_out_t branch_next;
    logic                  branch_done;

    always_ff @(posedge clock) begin
        if (reset) begin
            part <= '0;
        end else if (beat_valid) begin
            part <= (part == last_part) ? '0 : part + 1'b1;
        end
    end

    byte_alu alu_i (
        .clock  (clock),
        .reset  (reset),
        .valid  (beat_valid),
        .part   (part),
        .op     (beat.op),
        .rs1    (beat.rs1),
        .rs2    (beat.rs2),
        .result (alu_byte)
    );

    branch_unit branch_i (
        .clock   (clock),
        .reset   (reset),
        .valid   (beat_valid),
        .part    (part),
        .op      (beat.op),
        .rs1     (beat.rs1),
        .rs2     (beat.rs2),
        .imm     (beat.imm),
        .pc      (beat.pc),
        .done    (branch_done),
        .outcome (branch_next)
    );

    csr_bank #(
        .reset_trap_vector (reset_trap_vector)
    ) csr_i (
        .clock     (clock),
        .reset     (reset),
        .valid     (beat_valid),
        .part      (part),
        .op        (beat.op),
        .csr       (beat.csr),
        .rs1       (beat.rs1),
        .read_byte (csr_byte)
    );

    // one result byte per ALU or CSR beat
    // branches only report once, after part 7
    always_ff @(posedge clock) begin
        if (reset) begin
            result_valid <= 1'b0;
            branch_valid <= 1'b0;
        end else begin
            result_valid <= beat_valid &&
                            (exec_pkg::is_alu(beat.op) || exec_pkg::is_csr(beat.op));
            branch_valid <= branch_done;
        end
    end

    // CSR ops return the old CSR byte, everything else the ALU byte
    always_ff @(posedge clock) begin
        if (beat_valid) begin
            result <= exec_pkg::is_csr(beat.op) ? csr_byte : alu_byte;
        end
        if (branch_done) begin
            branch <= branch_next;
        end
    end

endmodule

`default_nettype wire

/* csr_bank.sv */
// machine CSR bank with mscratch and mtvec, read and written one byte per beat
`default_nettype none

module csr_bank #(
    parameter logic [exec_pkg::xlen_bytes*8-1:0] reset_trap_vector = '0
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                valid,
    input  exec_pkg::part_t     part,
    input  exec_pkg::op_t       op,
    input  exec_pkg::csr_addr_t csr,
    input  exec_pkg::byte_t     rs1,
    output exec_pkg::byte_t     read_byte
);

    localparam int word_bits = exec_pkg::xlen_bytes * 8;

    logic [word_bits-1:0] mscratch;
    // trap handler base address
    logic [word_bits-1:0] mtvec;
    logic [word_bits-1:0] read_word;
    exec_pkg::byte_t      write_byte;

    // read is combinational and returns the value before this instruction
    always_comb begin
        case (csr)
            exec_pkg::MSCRATCH: read_word = mscratch;
            // handler address is always word aligned
            exec_pkg::MTVEC:    read_word = {mtvec[word_bits-1:2], 2'b00};
            default:            read_word = '0;
        endcase
        read_byte = read_word[part*8 +: 8];
    end

    // new byte for write, set or clear
    always_comb begin
        case (op)
            exec_pkg::CSRRS: write_byte = read_byte | rs1;
            exec_pkg::CSRRC: write_byte = read_byte & ~rs1;
            default:         write_byte = rs1;
        endcase
    end

    // one byte updated per beat at the edge that samples it
    // unimplemented addresses fall through untouched
    always_ff @(posedge clock) begin
        if (reset) begin
            mscratch <= '0;
            mtvec <= reset_trap_vector;
        end else if (valid && exec_pkg::is_csr(op)) begin
            case (csr)
                exec_pkg::MSCRATCH: mscratch[part*8 +: 8] <= write_byte;
                exec_pkg::MTVEC:    mtvec[part*8 +: 8] <= write_byte;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* branch_unit.sv */
// byte-serial branch unit, chains the compare over eight beats and builds pc plus immediate
`default_nettype none

module branch_unit (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  valid,
    input  exec_pkg::part_t       part,
    input  exec_pkg::op_t         op,
    input  exec_pkg::byte_t       rs1,
    input  exec_pkg::byte_t       rs2,
    input  exec_pkg::byte_t       imm,
    input  exec_pkg::byte_t       pc,
    output logic                  done,
    output exec_pkg::branch_out_t outcome
);

    localparam exec_pkg::part_t last_part = exec_pkg::part_t'(exec_pkg::xlen_bytes - 1);
    localparam int word_bits = exec_pkg::xlen_bytes * 8;

    // equal so far for BEQ/BNE, less or greater so far for the ordered compares
    logic                 state_q;
    logic                 state_next;
    logic                 first;
    logic                 last;
    logic                 use_signed;
    logic                 eq;
    logic                 lt;
    logic                 gt;
    logic                 carry_q;
    logic [8:0]           target_sum;
    logic [word_bits-1:0] target_q;
    logic [word_bits-1:0] target_next;

    always_comb begin
        first = (part == '0);
        last = (part == last_part);
        // sign bit lives only in the top byte
        use_signed = last && (op == exec_pkg::BLT || op == exec_pkg::BGE);
        eq = (rs1 == rs2);
        lt = use_signed ? ($signed(rs1) < $signed(rs2)) : (rs1 < rs2);
        gt = use_signed ? ($signed(rs1) > $signed(rs2)) : (rs1 > rs2);
    end

    // a higher byte decides unless it is equal
    // then the verdict of the lower bytes stands
    always_comb begin
        case (op)
            exec_pkg::BEQ:                 state_next = eq && (first || state_q);
            exec_pkg::BNE:                 state_next = !eq || (!first && state_q);
            exec_pkg::BLT, exec_pkg::BLTU: state_next = lt || (eq && !first && state_q);
            exec_pkg::BGE, exec_pkg::BGEU: state_next = gt || (eq && (first || state_q));
            exec_pkg::JAL:                 state_next = 1'b1;
            default:                       state_next = 1'b0;
        endcase
    end

    // pc plus imm byte, new byte dropped into its slot of the target
    always_comb begin
        target_sum = {1'b0, pc} + {1'b0, imm} + {8'b0, !first && carry_q};
        target_next = target_q;
        target_next[part*8 +: 8] = target_sum[7:0];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= 1'b0;
            carry_q <= 1'b0;
        end else if (valid && exec_pkg::is_branch(op)) begin
            state_q <= state_next;
            carry_q <= target_sum[8];
        end
    end

    // lower target bytes collected as they are formed
    always_ff @(posedge clock) begin
        if (valid && exec_pkg::is_branch(op)) begin
            target_q <= target_next;
        end
    end

    always_comb begin
        done = valid && last && exec_pkg::is_branch(op);
        outcome.taken = state_next;
        outcome.target = target_next;
    end

endmodule

`default_nettype wire

/* byte_alu.sv */
// byte-serial ALU, one byte of add, sub, and, or or xor per beat with the carry held between beats
`default_nettype none

module byte_alu (
    input  logic            clock,
    input  logic            reset,
    input  logic            valid,
    input  exec_pkg::part_t part,
    input  exec_pkg::op_t   op,
    input  exec_pkg::byte_t rs1,
    input  exec_pkg::byte_t rs2,
    output exec_pkg::byte_t result
);

    logic            carry_q;
    logic            carry_in;
    logic            is_sub;
    exec_pkg::byte_t operand_b;
    logic [8:0]      sum;

    always_comb begin
        is_sub = (op == exec_pkg::SUB);
        // sub is rs1 plus inverted rs2 plus one
        operand_b = is_sub ? ~rs2 : rs2;
        // part 0 starts a new value so the stale carry is dropped
        carry_in = (part == '0) ? is_sub : carry_q;
        sum = {1'b0, rs1} + {1'b0, operand_b} + {8'b0, carry_in};
    end

    always_comb begin
        case (op)
            exec_pkg::ADD, exec_pkg::SUB: result = sum[7:0];
            exec_pkg::AND:                result = rs1 & rs2;
            exec_pkg::OR:                 result = rs1 | rs2;
            exec_pkg::XOR:                result = rs1 ^ rs2;
            default:                      result = '0;
        endcase
    end

    // carry out of this byte feeds the next part
    always_ff @(posedge clock) begin
        if (reset) begin
            carry_q <= 1'b0;
        end else if (valid && (op == exec_pkg::ADD || is_sub)) begin
            carry_q <= sum[8];
        end
    end

endmodule

`default_nettype wire

/* exec_pkg.sv */
// shared types, opcodes and width constants for the byte-serial execute stage, used by scoped name
`default_nettype none

package exec_pkg;

    // every 64-bit value travels as this many byte beats, lowest byte first
    localparam int xlen_bytes = 8;

    // beat index inside one operation
    typedef logic [2:0] part_t;
    typedef logic [7:0] byte_t;

    // execute opcodes
    typedef enum logic [3:0] {
        ADD   = 4'h0,
        SUB   = 4'h1,
        AND   = 4'h2,
        OR    = 4'h3,
        XOR   = 4'h4,
        BEQ   = 4'h5,
        BNE   = 4'h6,
        BLT   = 4'h7,
        BGE   = 4'h8,
        BLTU  = 4'h9,
        BGEU  = 4'ha,
        JAL   = 4'hb,
        CSRRW = 4'hc,
        CSRRS = 4'hd,
        CSRRC = 4'he
    } op_t;

    // machine CSR addresses that are implemented
    // any other address reads zero
    typedef enum logic [11:0] {
        MTVEC    = 12'h305,
        MSCRATCH = 12'h340
    } csr_addr_t;

    // one input beat, op and csr held for all eight beats
    typedef struct packed {
        op_t       op;
        csr_addr_t csr;
        byte_t     rs1;
        byte_t     rs2;
        byte_t     imm;
        byte_t     pc;
    } exec_beat_t;

    // branch decision and full target address
    typedef struct packed {
        logic                      taken;
        logic [xlen_bytes*8-1:0]   target;
    } branch_out_t;

    function automatic logic is_alu(op_t op);
        return op inside {ADD, SUB, AND, OR, XOR};
    endfunction

    // JAL counts as a branch that is always taken
    function automatic logic is_branch(op_t op);
        return op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL};
    endfunction

    function automatic logic is_csr(op_t op);
        return op inside {CSRRW, CSRRS, CSRRC};
    endfunction

endpackage

`default_nettype wire
